/* hdl/emmc_cmd_pkg.sv */
package emmc_cmd_pkg;

    localparam int FRAME_BITS = 48;
    // start, direction, index and argument, all covered by the crc
    localparam int HEAD_BITS  = 40;
    // response start bit must show up within this many cycles
    localparam int NCR_MAX    = 64;

    typedef logic [5:0]            cmd_index_t;
    typedef logic [31:0]           cmd_arg_t;
    typedef logic [6:0]            crc7_t;
    typedef logic [FRAME_BITS-1:0] frame_t;
    // holds a frame bit index as well as the response wait count
    typedef logic [$clog2(NCR_MAX)-1:0] bit_cnt_t;

    typedef struct packed {
        cmd_index_t index;
        cmd_arg_t   arg;
        logic       resp_expected;
    } cmd_req_t;

    typedef struct packed {
        logic crc_err;
        logic index_err;
        logic timeout;
    } dev_flags_t;

    typedef struct packed {
        cmd_arg_t   status;
        dev_flags_t flags;
        logic       valid;
    } resp_t;

    typedef struct packed {
        dev_flags_t dev0;
        dev_flags_t dev1;
        logic       mismatch;
    } cmd_status_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SHIFT,
        TX_WAIT_RESP
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_WAIT_START,
        RX_SHIFT,
        RX_DONE
    } rx_state_e;

endpackage

/* hdl/cmd_crc7.sv */
`timescale 1ns/1ns

module cmd_crc7 import emmc_cmd_pkg::*; (
    input  logic  sd_clk_i,
    input  logic  arst_n_i,
    input  logic  clear_i,
    input  logic  shift_i,
    input  logic  bit_i,
    output crc7_t crc_o
);

    crc7_t crc_q;
    logic  fb;

    // x^7 + x^3 + 1
    assign fb = bit_i ^ crc_q[6];

    always_ff @(posedge sd_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            crc_q <= '0;
        end else if (clear_i) begin
            crc_q <= '0;
        end else if (shift_i) begin
            crc_q <= {crc_q[5:3], crc_q[2] ^ fb, crc_q[1:0], fb};
        end
    end

    assign crc_o = crc_q;

endmodule

/* hdl/cmd_frame_tx.sv */
`timescale 1ns/1ns

module cmd_frame_tx import emmc_cmd_pkg::*; (
    input  logic       sd_clk_i,
    input  logic       arst_n_i,
    input  logic       start_i,
    input  cmd_req_t   req_i,
    output logic       cmd_o,
    output logic       cmd_oe_o,
    output logic       tx_end_o,
    output cmd_index_t index_o,
    output logic       resp_expected_o
);

    tx_state_e  state_q;
    bit_cnt_t   cnt_q;
    frame_t     shift_q;
    cmd_index_t index_q;
    logic       resp_exp_q;
    crc7_t      crc;
    logic       in_crc;
    logic       tx_bit;
    logic       last_bit;

    // crc field sits between the head and the end bit
    assign in_crc   = (cnt_q >= bit_cnt_t'(HEAD_BITS)) &&
                      (cnt_q < bit_cnt_t'(FRAME_BITS-1));
    assign tx_bit   = in_crc ? crc[6] : shift_q[FRAME_BITS-1];
    assign last_bit = (state_q == TX_SHIFT) && (cnt_q == bit_cnt_t'(FRAME_BITS-1));

    // feeding the msb back empties the crc register msb first
    cmd_crc7 i_crc (
        .sd_clk_i (sd_clk_i),
        .arst_n_i (arst_n_i),
        .clear_i  (start_i),
        .shift_i  ((state_q == TX_SHIFT) && !last_bit),
        .bit_i    (tx_bit),
        .crc_o    (crc)
    );

    always_ff @(posedge sd_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= TX_IDLE;
            cnt_q      <= '0;
            index_q    <= '0;
            resp_exp_q <= 1'b0;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    if (start_i) begin
                        index_q    <= req_i.index;
                        resp_exp_q <= req_i.resp_expected;
                        cnt_q      <= '0;
                        state_q    <= TX_SHIFT;
                    end
                end
                TX_SHIFT: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_bit) begin
                        cnt_q   <= '0;
                        state_q <= resp_exp_q ? TX_WAIT_RESP : TX_IDLE;
                    end
                end
                // line released, hold off for at least one response length
                TX_WAIT_RESP: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == bit_cnt_t'(FRAME_BITS-1))
                        state_q <= TX_IDLE;
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // start, direction, index, argument, then ones past the head
    always_ff @(posedge sd_clk_i) begin
        if ((state_q == TX_IDLE) && start_i)
            shift_q <= {2'b01, req_i.index, req_i.arg, 8'hff};
        else if (state_q == TX_SHIFT)
            shift_q <= {shift_q[FRAME_BITS-2:0], 1'b1};
    end

    assign cmd_oe_o        = (state_q == TX_SHIFT);
    assign cmd_o           = cmd_oe_o ? tx_bit : 1'b1;
    assign tx_end_o        = last_bit;
    assign index_o         = index_q;
    assign resp_expected_o = resp_exp_q;

    // host must wait for the previous command to finish
    a_start_idle: assert property (@(posedge sd_clk_i) disable iff (!arst_n_i)
        start_i |-> (state_q == TX_IDLE));

endmodule

/* hdl/resp_frame_rx.sv */
`timescale 1ns/1ns

module resp_frame_rx import emmc_cmd_pkg::*; (
    input  logic       sd_clk_i,
    input  logic       arst_n_i,
    input  logic       arm_i,
    input  cmd_index_t index_i,
    input  logic       cmd_i,
    output resp_t      resp_o
);

    rx_state_e               state_q;
    bit_cnt_t                cnt_q;
    logic [FRAME_BITS-2:0]   shift_q;
    frame_t                  rx_frame;
    cmd_arg_t                status_q;
    dev_flags_t              flags_q;
    crc7_t                   crc;
    logic                    start_seen;
    logic                    expired;
    logic                    last_bit;

    assign rx_frame   = {shift_q, cmd_i};
    assign start_seen = (state_q == RX_WAIT_START) && !cmd_i;
    assign expired    = (state_q == RX_WAIT_START) && cmd_i &&
                        (cnt_q == bit_cnt_t'(NCR_MAX-1));
    assign last_bit   = (state_q == RX_SHIFT) && (cnt_q == bit_cnt_t'(FRAME_BITS-1));

    // start bit counts as the first of the 40 covered bits
    cmd_crc7 i_crc (
        .sd_clk_i (sd_clk_i),
        .arst_n_i (arst_n_i),
        .clear_i  (arm_i),
        .shift_i  (start_seen ||
                   ((state_q == RX_SHIFT) && (cnt_q < bit_cnt_t'(HEAD_BITS)))),
        .bit_i    (cmd_i),
        .crc_o    (crc)
    );

    always_ff @(posedge sd_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= RX_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                RX_IDLE: begin
                    if (arm_i) begin
                        cnt_q   <= bit_cnt_t'(1);
                        state_q <= RX_WAIT_START;
                    end
                end
                RX_WAIT_START: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (start_seen) begin
                        cnt_q   <= bit_cnt_t'(1);
                        state_q <= RX_SHIFT;
                    end else if (expired) begin
                        state_q <= RX_DONE;
                    end
                end
                RX_SHIFT: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_bit)
                        state_q <= RX_DONE;
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge sd_clk_i) begin
        if (start_seen || (state_q == RX_SHIFT))
            shift_q <= rx_frame[FRAME_BITS-2:0];
        if (expired) begin
            status_q <= '0;
            flags_q  <= '{crc_err: 1'b0, index_err: 1'b0, timeout: 1'b1};
        end else if (last_bit) begin
            // index 45:40, status 39:8, crc 7:1
            status_q          <= rx_frame[39:8];
            flags_q.crc_err   <= (rx_frame[7:1] != crc);
            flags_q.index_err <= (rx_frame[45:40] != index_i);
            flags_q.timeout   <= 1'b0;
        end
    end

    assign resp_o.status = status_q;
    assign resp_o.flags  = flags_q;
    assign resp_o.valid  = (state_q == RX_DONE);

    a_valid_pulse: assert property (@(posedge sd_clk_i) disable iff (!arst_n_i)
        resp_o.valid |=> !resp_o.valid);

endmodule

/* hdl/resp_merge.sv */
`timescale 1ns/1ns

module resp_merge import emmc_cmd_pkg::*; (
    input  logic        sd_clk_i,
    input  logic        arst_n_i,
    input  logic        start_i,
    input  logic        tx_end_i,
    input  logic        resp_expected_i,
    input  resp_t       resp0_i,
    input  resp_t       resp1_i,
    output logic        busy_o,
    output logic        done_o,
    output cmd_status_t status_o,
    output cmd_arg_t    response_o
);

    resp_t       resp0_q;
    resp_t       resp1_q;
    resp_t       r0;
    resp_t       r1;
    logic        got0_q;
    logic        got1_q;
    logic        busy_q;
    logic        done_q;
    logic        both_in;
    logic        no_resp;
    logic        finish;
    cmd_status_t status_q;
    cmd_arg_t    response_q;

    // a result arriving this cycle counts as already held
    assign r0      = resp0_i.valid ? resp0_i : resp0_q;
    assign r1      = resp1_i.valid ? resp1_i : resp1_q;
    assign both_in = busy_q && (got0_q || resp0_i.valid) && (got1_q || resp1_i.valid);
    assign no_resp = tx_end_i && !resp_expected_i;
    assign finish  = both_in || no_resp;

    always_ff @(posedge sd_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            got0_q <= 1'b0;
            got1_q <= 1'b0;
        end else begin
            done_q <= finish;
            if (start_i)
                busy_q <= 1'b1;
            else if (done_q)
                busy_q <= 1'b0;
            if (start_i || finish) begin
                got0_q <= 1'b0;
                got1_q <= 1'b0;
            end else begin
                if (busy_q && resp0_i.valid)
                    got0_q <= 1'b1;
                if (busy_q && resp1_i.valid)
                    got1_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge sd_clk_i) begin
        if (resp0_i.valid)
            resp0_q <= resp0_i;
        if (resp1_i.valid)
            resp1_q <= resp1_i;
        if (no_resp) begin
            status_q   <= '0;
            response_q <= '0;
        end else if (both_in) begin
            status_q.dev0     <= r0.flags;
            status_q.dev1     <= r1.flags;
            status_q.mismatch <= !(|r0.flags) && !(|r1.flags) && (r0.status != r1.status);
            response_q        <= r0.status;
        end
    end

    assign busy_o     = busy_q;
    assign done_o     = done_q;
    assign status_o   = status_q;
    assign response_o = response_q;

    a_done_busy: assert property (@(posedge sd_clk_i) disable iff (!arst_n_i)
        done_o |-> busy_o);

endmodule

/* hdl/raid0_cmd_top.sv */
`timescale 1ns/1ns

module raid0_cmd_top import emmc_cmd_pkg::*; (
    input  logic        sd_clk_i,
    input  logic        arst_n_i,
    input  logic        start_i,
    input  cmd_req_t    req_i,
    output logic        sd_cmd0_o,
    output logic        sd_cmd0_oe_o,
    input  logic        sd_cmd0_i,
    output logic        sd_cmd1_o,
    output logic        sd_cmd1_oe_o,
    input  logic        sd_cmd1_i,
    output logic        busy_o,
    output logic        done_o,
    output cmd_status_t status_o,
    output cmd_arg_t    response_o
);

    logic       tx_cmd;
    logic       tx_oe;
    logic       tx_end;
    logic       resp_expected;
    cmd_index_t tx_index;
    resp_t      resp0;
    resp_t      resp1;

    cmd_frame_tx i_tx (
        .sd_clk_i        (sd_clk_i),
        .arst_n_i        (arst_n_i),
        .start_i         (start_i),
        .req_i           (req_i),
        .cmd_o           (tx_cmd),
        .cmd_oe_o        (tx_oe),
        .tx_end_o        (tx_end),
        .index_o         (tx_index),
        .resp_expected_o (resp_expected)
    );

    // both devices get the same command bit
    assign sd_cmd0_o    = tx_cmd;
    assign sd_cmd0_oe_o = tx_oe;
    assign sd_cmd1_o    = tx_cmd;
    assign sd_cmd1_oe_o = tx_oe;

    resp_frame_rx i_rx0 (
        .sd_clk_i (sd_clk_i),
        .arst_n_i (arst_n_i),
        .arm_i    (tx_end && resp_expected),
        .index_i  (tx_index),
        .cmd_i    (sd_cmd0_i),
        .resp_o   (resp0)
    );

    resp_frame_rx i_rx1 (
        .sd_clk_i (sd_clk_i),
        .arst_n_i (arst_n_i),
        .arm_i    (tx_end && resp_expected),
        .index_i  (tx_index),
        .cmd_i    (sd_cmd1_i),
        .resp_o   (resp1)
    );

    resp_merge i_merge (
        .sd_clk_i        (sd_clk_i),
        .arst_n_i        (arst_n_i),
        .start_i         (start_i),
        .tx_end_i        (tx_end),
        .resp_expected_i (resp_expected),
        .resp0_i         (resp0),
        .resp1_i         (resp1),
        .busy_o          (busy_o),
        .done_o          (done_o),
        .status_o        (status_o),
        .response_o      (response_o)
    );

endmodule

/* test/cmd_checker.sv */
`timescale 1ns/1ns

module cmd_checker import emmc_cmd_pkg::*; (
    input  logic        sd_clk_i,
    input  logic        arst_n_i,
    input  logic        start_i,
    input  cmd_req_t    req_i,
    input  int          test_i,
    input  dev_flags_t  fault0_i,
    input  dev_flags_t  fault1_i,
    input  cmd_arg_t    card0_status_i,
    input  cmd_arg_t    card1_status_i,
    input  logic        cmd0_i,
    input  logic        cmd0_oe_i,
    input  logic        cmd1_i,
    input  logic        cmd1_oe_i,
    input  logic        busy_i,
    input  logic        done_i,
    input  cmd_status_t status_i,
    input  cmd_arg_t    response_i,
    output int          tests_o,
    output int          failed_o
);

    cmd_req_t req_q;
    frame_t   frame0_q;
    frame_t   frame1_q;
    int       cyc_q;
    int       end_cyc_q;
    int       errors;
    logic     in_flight_q;
    logic     busy_low_q;

    function automatic string test_name(input int num);
        case (num)
            1: return "no_response";
            2: return "r1_both_ok";
            3: return "dev1_bad_crc";
            4: return "dev0_bad_index";
            5: return "dev1_silent";
            6: return "status_mismatch";
            default: return "unknown";
        endcase
    endfunction

    // start, direction, index, argument, crc7 over those 40 bits, end bit
    function automatic frame_t expected_frame(input cmd_req_t req);
        logic [39:0] head;
        crc7_t       crc;
        logic        fb;
        head = {2'b01, req.index, req.arg};
        crc  = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = head[i] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ {3'b000, fb, 2'b00, fb};
        end
        return {head, crc, 1'b1};
    endfunction

    // flags follow the fault injected into each card
    function automatic cmd_status_t expected_status(input cmd_req_t req,
                                                    input dev_flags_t f0,
                                                    input dev_flags_t f1,
                                                    input cmd_arg_t s0,
                                                    input cmd_arg_t s1);
        cmd_status_t st;
        st = '0;
        if (req.resp_expected) begin
            st.dev0     = f0;
            st.dev1     = f1;
            st.mismatch = (f0 == 3'b000) && (f1 == 3'b000) && (s0 != s1);
        end
        return st;
    endfunction

    // device 0 status as received or zero when it never answered
    function automatic cmd_arg_t expected_response(input cmd_req_t req,
                                                   input dev_flags_t f0,
                                                   input cmd_arg_t s0);
        if (!req.resp_expected || f0.timeout)
            return '0;
        return s0;
    endfunction

    task automatic compare(input string what, input logic [47:0] exp,
                           input logic [47:0] act);
        if (act !== exp) begin
            $display("** Error %s: %s expected %h, actual %h",
                     test_name(test_i), what, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic check_result();
        frame_t      exp_frame;
        cmd_status_t exp_status;
        cmd_arg_t    exp_resp;
        exp_frame  = expected_frame(req_q);
        exp_status = expected_status(req_q, fault0_i, fault1_i,
                                     card0_status_i, card1_status_i);
        exp_resp   = expected_response(req_q, fault0_i, card0_status_i);
        compare("frame on line 0", exp_frame, frame0_q);
        compare("frame on line 1", exp_frame, frame1_q);
        compare("status", 48'(exp_status), 48'(status_i));
        compare("response", 48'(exp_resp), 48'(response_i));
        // done follows the end bit directly when no response is due
        if (!req_q.resp_expected)
            compare("done cycle", 48'(end_cyc_q + 1), 48'(cyc_q));
        tests_o = tests_o + 1;
        if (errors == 0) begin
            $display("%s passed", test_name(test_i));
        end else begin
            failed_o = failed_o + 1;
            $display("%s failed with %0d errors", test_name(test_i), errors);
        end
    endtask

    always @(posedge sd_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cyc_q       = 0;
            end_cyc_q   = 0;
            errors      = 0;
            tests_o     = 0;
            failed_o    = 0;
            in_flight_q = 1'b0;
            busy_low_q  = 1'b0;
        end else begin
            // busy stays up from the cycle after start up to done
            if (in_flight_q && !busy_low_q && busy_i !== 1'b1) begin
                compare("busy", 48'd1, 48'(busy_i));
                busy_low_q = 1'b1;
            end
            if (start_i) begin
                req_q       = req_i;
                errors      = 0;
                in_flight_q = 1'b1;
                busy_low_q  = 1'b0;
            end
            if (cmd0_oe_i) begin
                frame0_q  = {frame0_q[FRAME_BITS-2:0], cmd0_i};
                end_cyc_q = cyc_q;
            end
            if (cmd1_oe_i)
                frame1_q = {frame1_q[FRAME_BITS-2:0], cmd1_i};
            if (done_i) begin
                check_result();
                in_flight_q = 1'b0;
            end
            cyc_q = cyc_q + 1;
        end
    end

endmodule

/* test/tb_raid0_cmd.sv */
`timescale 1ns/1ns

module tb_raid0_cmd import emmc_cmd_pkg::*; ();

    localparam int NUM_TESTS   = 6;
    // 6 tests of at most 48 + 64 + 48 cycles plus gaps and margin
    localparam int CYCLE_LIMIT = 4000;

    logic        sd_clk;
    logic        arst_n;
    logic        start;
    cmd_req_t    req;
    logic [1:0]  line_out;
    logic [1:0]  line_oe;
    logic [1:0]  card_line;
    logic        busy;
    logic        done;
    cmd_status_t status;
    cmd_arg_t    response;
    int          test_num;
    dev_flags_t  fault [2];
    cmd_arg_t    card_status [2];
    int          resp_delay [2];
    int          tests;
    int          failed;
    int          cycles = 0;
    integer      seed;

    raid0_cmd_top i_raid0_cmd_top (
        .sd_clk_i     (sd_clk),
        .arst_n_i     (arst_n),
        .start_i      (start),
        .req_i        (req),
        .sd_cmd0_o    (line_out[0]),
        .sd_cmd0_oe_o (line_oe[0]),
        .sd_cmd0_i    (card_line[0]),
        .sd_cmd1_o    (line_out[1]),
        .sd_cmd1_oe_o (line_oe[1]),
        .sd_cmd1_i    (card_line[1]),
        .busy_o       (busy),
        .done_o       (done),
        .status_o     (status),
        .response_o   (response)
    );

    cmd_checker i_checker (
        .sd_clk_i       (sd_clk),
        .arst_n_i       (arst_n),
        .start_i        (start),
        .req_i          (req),
        .test_i         (test_num),
        .fault0_i       (fault[0]),
        .fault1_i       (fault[1]),
        .card0_status_i (card_status[0]),
        .card1_status_i (card_status[1]),
        .cmd0_i         (line_out[0]),
        .cmd0_oe_i      (line_oe[0]),
        .cmd1_i         (line_out[1]),
        .cmd1_oe_i      (line_oe[1]),
        .busy_i         (busy),
        .done_i         (done),
        .status_i       (status),
        .response_i     (response),
        .tests_o        (tests),
        .failed_o       (failed)
    );

    initial begin
        sd_clk = 1'b0;
        forever #4 sd_clk = ~sd_clk;
    end

    always @(posedge sd_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, done_o never came for test %0d",
                     cycles, test_num);
            $display("TEST FAIL");
            $finish;
        end
    end

    // x^7 + x^3 + 1 over the 40 head bits msb first
    function automatic crc7_t crc7_of(input logic [39:0] head);
        crc7_t c;
        logic  fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = head[i] ^ c[6];
            c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    // decode one command and build the card's answer after the delay
    task automatic take_command(input int dev, output frame_t resp, output logic send);
        frame_t     cmd_rx;
        cmd_index_t idx;
        crc7_t      crc;
        send = 1'b0;
        @(posedge sd_clk);
        while (line_oe[dev] !== 1'b1)
            @(posedge sd_clk);
        for (int i = 0; i < FRAME_BITS; i++) begin
            cmd_rx = {cmd_rx[FRAME_BITS-2:0], line_out[dev]};
            @(posedge sd_clk);
        end
        idx = cmd_rx[45:40];
        // index 0 gets no response
        if (idx != '0 && !fault[dev].timeout) begin
            repeat (resp_delay[dev]) @(posedge sd_clk);
            if (fault[dev].index_err)
                idx = ~idx;
            crc = crc7_of({2'b00, idx, card_status[dev]});
            if (fault[dev].crc_err)
                crc = crc ^ 7'h01;
            resp = {2'b00, idx, card_status[dev], crc, 1'b1};
            send = 1'b1;
        end
    endtask

    for (genvar g = 0; g < 2; g++) begin : g_card
        logic line;

        assign card_line[g] = line;

        initial begin
            frame_t resp;
            logic   send;
            line <= 1'b1;
            forever begin
                take_command(g, resp, send);
                if (send) begin
                    for (int i = FRAME_BITS - 1; i >= 0; i--) begin
                        line <= resp[i];
                        @(posedge sd_clk);
                    end
                    line <= 1'b1;
                end
            end
        end
    end

    // fault bits are crc, index, timeout
    task automatic run_test(input int num, input cmd_index_t index, input logic resp_exp,
                            input dev_flags_t f0, input dev_flags_t f1,
                            input cmd_arg_t s0, input cmd_arg_t s1);
        cmd_req_t r;
        r.index         = index;
        r.arg           = $random(seed);
        r.resp_expected = resp_exp;
        @(posedge sd_clk);
        while (busy)
            @(posedge sd_clk);
        test_num       <= num;
        req            <= r;
        fault[0]       <= f0;
        fault[1]       <= f1;
        card_status[0] <= s0;
        card_status[1] <= s1;
        resp_delay[0]  <= 2 + int'({$random(seed)} % 19);
        resp_delay[1]  <= 2 + int'({$random(seed)} % 19);
        start          <= 1'b1;
        @(posedge sd_clk);
        start <= 1'b0;
        while (!done)
            @(posedge sd_clk);
        repeat (4) @(posedge sd_clk);
    endtask

    initial begin
        cmd_arg_t st;
        seed           = 32793;
        arst_n         <= 1'b0;
        start          <= 1'b0;
        req            <= '0;
        test_num       <= 0;
        fault[0]       <= '0;
        fault[1]       <= '0;
        card_status[0] <= '0;
        card_status[1] <= '0;
        resp_delay[0]  <= 2;
        resp_delay[1]  <= 2;
        repeat (8) @(posedge sd_clk);
        arst_n <= 1'b1;
        st = $random(seed);
        run_test(1, 6'd0, 1'b0, 3'b000, 3'b000, st, st);
        st = $random(seed);
        run_test(2, 6'd13, 1'b1, 3'b000, 3'b000, st, st);
        st = $random(seed);
        run_test(3, 6'd13, 1'b1, 3'b000, 3'b100, st, st);
        st = $random(seed);
        run_test(4, 6'd17, 1'b1, 3'b010, 3'b000, st, st);
        st = $random(seed);
        run_test(5, 6'd13, 1'b1, 3'b000, 3'b001, st, st);
        st = $random(seed);
        run_test(6, 6'd13, 1'b1, 3'b000, 3'b000, st, ~st);
        repeat (4) @(posedge sd_clk);
        $display("tests run %0d of %0d, tests failed %0d", tests, NUM_TESTS, failed);
        if (failed == 0 && tests == NUM_TESTS)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* sources.f */
hdl/emmc_cmd_pkg.sv
hdl/cmd_crc7.sv
hdl/cmd_frame_tx.sv
hdl/resp_frame_rx.sv
hdl/resp_merge.sv
hdl/raid0_cmd_top.sv
test/cmd_checker.sv
test/tb_raid0_cmd.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_raid0_cmd -Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
